//--- Makefile
# Verilator build of the video pipeline testbench

TOP = tb_vid_board

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f list.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "=== PASS ==="

clean:
	rm -rf obj_dir

//--- list.f
+incdir+rtl
rtl/vid_pkg.sv
rtl/vid_capture.sv
rtl/vid_bw_filter.sv
rtl/vid_out_stage.sv
rtl/vid_board_top.sv
testbench/tb_vid_board.sv

//--- rtl/vid_board_top.sv
// ctrl is sampled as static levels; vid_out trails the game inputs by VID_LATENCY pxl_cen strobes
`timescale 1ns/100ps
`include "vid_cfg.svh"

module vid_board_top import vid_pkg::*; (
    input  logic                   clk_sys,
    input  logic                   rst_n,
    input  logic                   pxl_cen,
    input  logic [`VID_COLORW-1:0] game_r,
    input  logic [`VID_COLORW-1:0] game_g,
    input  logic [`VID_COLORW-1:0] game_b,
    input  logic                   lhbl,
    input  logic                   lvbl,
    input  logic                   hs,
    input  logic                   vs,
    input  vid_ctrl_t              ctrl,
    output vid_out_t               vid,
    output logic                   vid_cen
);

    game_pixel_t cap_pix;
    filt_pixel_t filt_pix;

    // First strobe of latency
    vid_capture u_capture (
        .clk_sys ( clk_sys  ),
        .rst_n   ( rst_n    ),
        .pxl_cen ( pxl_cen  ),
        .game_r  ( game_r   ),
        .game_g  ( game_g   ),
        .game_b  ( game_b   ),
        .lhbl    ( lhbl     ),
        .lvbl    ( lvbl     ),
        .hs      ( hs       ),
        .vs      ( vs       ),
        .pix     ( cap_pix  )
    );

    // Second strobe
    vid_bw_filter u_bw_filter (
        .clk_sys ( clk_sys    ),
        .rst_n   ( rst_n      ),
        .pxl_cen ( pxl_cen    ),
        .bw_en   ( ctrl.bw_en ),
        .pix_in  ( cap_pix    ),
        .pix_out ( filt_pix   )
    );

    // Third strobe, vid_cen one clk_sys later
    vid_out_stage u_out_stage (
        .clk_sys ( clk_sys      ),
        .rst_n   ( rst_n        ),
        .pxl_cen ( pxl_cen      ),
        .sl_mode ( ctrl.sl_mode ),
        .pix_in  ( filt_pix     ),
        .vid     ( vid          ),
        .vid_cen ( vid_cen      )
    );

endmodule

//--- rtl/vid_bw_filter.sv
// Filter runs through blanking too, so the first active pixel is summed with the last blank one
`timescale 1ns/100ps
`include "vid_cfg.svh"

module vid_bw_filter import vid_pkg::*; (
    input  logic        clk_sys,
    input  logic        rst_n,
    input  logic        pxl_cen,
    input  logic        bw_en,
    input  game_pixel_t pix_in,
    output filt_pixel_t pix_out
);

    // Colour of the previous input pixel
    logic [`VID_COLORW-1:0] prev_r;
    logic [`VID_COLORW-1:0] prev_g;
    logic [`VID_COLORW-1:0] prev_b;

    // Two-tap sum softens edges like a slow analogue wire
    // without the filter the value is doubled to keep the same scale
    function automatic logic [`VID_FILTW-1:0] filt(
        input logic [`VID_COLORW-1:0] cur,
        input logic [`VID_COLORW-1:0] prev,
        input logic                   en
    );
        if (en) begin
            filt = {1'b0, cur} + {1'b0, prev};
        end else begin
            filt = {cur, 1'b0};
        end
    endfunction

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            prev_r  <= '0;
            prev_g  <= '0;
            prev_b  <= '0;
            pix_out <= '0;
        end else if (pxl_cen) begin
            prev_r <= pix_in.r;
            prev_g <= pix_in.g;
            prev_b <= pix_in.b;

            pix_out.r <= filt(pix_in.r, prev_r, bw_en);
            pix_out.g <= filt(pix_in.g, prev_g, bw_en);
            pix_out.b <= filt(pix_in.b, prev_b, bw_en);

            // Timing signals get the same delay as the colour
            pix_out.lhbl     <= pix_in.lhbl;
            pix_out.lvbl     <= pix_in.lvbl;
            pix_out.hs       <= pix_in.hs;
            pix_out.vs       <= pix_in.vs;
            pix_out.line_odd <= pix_in.line_odd;
        end
    end

    // Doubling leaves the low bit clear on the next registered pixel
    a_double_even: assert property (
        @(posedge clk_sys) disable iff (!rst_n)
        (pxl_cen && !bw_en) |=> !(pix_out.r[0] || pix_out.g[0] || pix_out.b[0])
    ) else $error("odd channel value with filter disabled");

endmodule

//--- rtl/vid_capture.sv
// Needs pxl_cen as a single-cycle strobe; blanking inputs are active low, line parity resets in vblank
`timescale 1ns/100ps
`include "vid_cfg.svh"

module vid_capture import vid_pkg::*; (
    input  logic                   clk_sys,
    input  logic                   rst_n,
    input  logic                   pxl_cen,
    input  logic [`VID_COLORW-1:0] game_r,
    input  logic [`VID_COLORW-1:0] game_g,
    input  logic [`VID_COLORW-1:0] game_b,
    input  logic                   lhbl,
    input  logic                   lvbl,
    input  logic                   hs,
    input  logic                   vs,
    output game_pixel_t            pix
);

    logic line_end;
    logic next_odd;

    // pix.lhbl already holds lhbl from the previous strobe
    assign line_end = pix.lhbl & ~lhbl;

    // Parity restarts during vertical blank so the first active line is even
    always_comb begin
        if (!lvbl) begin
            next_odd = 1'b0;
        end else if (line_end) begin
            next_odd = ~pix.line_odd;
        end else begin
            next_odd = pix.line_odd;
        end
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            pix <= '0;
        end else if (pxl_cen) begin
            pix.r        <= game_r;
            pix.g        <= game_g;
            pix.b        <= game_b;
            pix.lhbl     <= lhbl;
            pix.lvbl     <= lvbl;
            pix.hs       <= hs;
            pix.vs       <= vs;
            pix.line_odd <= next_odd;
        end
    end

    // The whole pipeline assumes one strobe per pixel, never back to back
    a_cen_single: assert property (
        @(posedge clk_sys) disable iff (!rst_n)
        pxl_cen |=> !pxl_cen
    ) else $error("pxl_cen high in two consecutive cycles");

endmodule

//--- rtl/vid_cfg.svh
// Widths are fixed for 4-bit game colour and 8-bit output; VID_FILTW must stay VID_COLORW + 1
`ifndef VID_CFG_SVH
`define VID_CFG_SVH

// Game colour per channel
`define VID_COLORW 4

// One extra bit after the bandwidth filter
`define VID_FILTW (`VID_COLORW + 1)

// Output colour per channel
`define VID_OUTW 8

// Capture, filter and output registers
`define VID_LATENCY 3

`endif

//--- rtl/vid_out_stage.sv
// Extension is by bit replication, so full scale maps to 8'hff; dimming acts only on odd lines
`timescale 1ns/100ps
`include "vid_cfg.svh"

module vid_out_stage import vid_pkg::*; (
    input  logic        clk_sys,
    input  logic        rst_n,
    input  logic        pxl_cen,
    input  sl_level_t   sl_mode,
    input  filt_pixel_t pix_in,
    output vid_out_t    vid,
    output logic        vid_cen
);

    logic                 de;
    sl_level_t            level;
    logic [`VID_OUTW-1:0] r8;
    logic [`VID_OUTW-1:0] g8;
    logic [`VID_OUTW-1:0] b8;

    // Append the top bits to reach the output width
    function automatic logic [`VID_OUTW-1:0] extend8(input logic [`VID_FILTW-1:0] c);
        extend8 = {c, c[`VID_FILTW-1 -: (`VID_OUTW - `VID_FILTW)]};
    endfunction

    // Scanline intensity
    function automatic logic [`VID_OUTW-1:0] dim(
        input logic [`VID_OUTW-1:0] v,
        input sl_level_t            lvl
    );
        case (lvl)
            SL_3Q:   dim = v - (v >> 2);
            SL_HALF: dim = v >> 1;
            SL_1Q:   dim = v >> 2;
            default: dim = v;
        endcase
    endfunction

    assign de    = pix_in.lhbl & pix_in.lvbl;
    assign level = pix_in.line_odd ? sl_mode : SL_OFF;

    always_comb begin
        r8 = '0;
        g8 = '0;
        b8 = '0;
        // Black outside the active area
        if (de) begin
            r8 = dim(extend8(pix_in.r), level);
            g8 = dim(extend8(pix_in.g), level);
            b8 = dim(extend8(pix_in.b), level);
        end
    end

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            vid     <= '0;
            vid_cen <= 1'b0;
        end else begin
            // Marks the cycle right after the output register loads
            vid_cen <= pxl_cen;
            if (pxl_cen) begin
                vid.r  <= r8;
                vid.g  <= g8;
                vid.b  <= b8;
                vid.hs <= pix_in.hs;
                vid.vs <= pix_in.vs;
                vid.de <= de;
            end
        end
    end

    a_blank_black: assert property (
        @(posedge clk_sys) disable iff (!rst_n)
        !vid.de |-> (vid.r == '0 && vid.g == '0 && vid.b == '0)
    ) else $error("colour not zero outside the active area");

endmodule

//--- rtl/vid_pkg.sv
// Stage structs follow the widths in vid_cfg.svh; field order is part of the bit layout
`include "vid_cfg.svh"

package vid_pkg;

    // Scanline dimming level for odd lines
    typedef logic [1:0] sl_level_t;

    localparam sl_level_t SL_OFF  = 2'd0;
    localparam sl_level_t SL_3Q   = 2'd1;
    localparam sl_level_t SL_HALF = 2'd2;
    localparam sl_level_t SL_1Q   = 2'd3;

    // Static user controls
    typedef struct packed {
        logic      bw_en;
        sl_level_t sl_mode;
    } vid_ctrl_t;

    // Pixel as sampled from the game
    typedef struct packed {
        logic [`VID_COLORW-1:0] r;
        logic [`VID_COLORW-1:0] g;
        logic [`VID_COLORW-1:0] b;
        logic                   lhbl;
        logic                   lvbl;
        logic                   hs;
        logic                   vs;
        logic                   line_odd;
    } game_pixel_t;

    // Pixel after the bandwidth filter
    typedef struct packed {
        logic [`VID_FILTW-1:0] r;
        logic [`VID_FILTW-1:0] g;
        logic [`VID_FILTW-1:0] b;
        logic                  lhbl;
        logic                  lvbl;
        logic                  hs;
        logic                  vs;
        logic                  line_odd;
    } filt_pixel_t;

    // Final video word
    typedef struct packed {
        logic [`VID_OUTW-1:0] r;
        logic [`VID_OUTW-1:0] g;
        logic [`VID_OUTW-1:0] b;
        logic                 hs;
        logic                 vs;
        logic                 de;
    } vid_out_t;

endpackage

//--- testbench/tb_vid_board.sv
// Strobe every second cycle; ctrl may change only at frame starts, with blanking in flight
`timescale 1ns/100ps
`include "vid_cfg.svh"

module tb_vid_board import vid_pkg::*; ();

    localparam int CLK_PERIOD  = 10;
    localparam int LINE_PIX    = 12;
    localparam int BLANK_PIX   = 3;
    // One vertical blank line, then four active lines
    localparam int FRAME_LINES = 5;
    localparam int FRAME_PIX   = LINE_PIX * FRAME_LINES;
    localparam int NUM_ROWS    = 8;
    localparam int TOTAL_STROBES = NUM_ROWS * FRAME_PIX + `VID_LATENCY - 1;
    localparam int WATCHDOG_NS = (TOTAL_STROBES * 2 + 10 + 50) * CLK_PERIOD;

    typedef struct packed {
        logic       bw_en;
        sl_level_t  sl_mode;
        logic [1:0] pattern;
    } stim_row_t;

    logic                   clk_sys;
    logic                   rst_n;
    logic                   pxl_cen;
    logic [`VID_COLORW-1:0] game_r;
    logic [`VID_COLORW-1:0] game_g;
    logic [`VID_COLORW-1:0] game_b;
    logic                   lhbl;
    logic                   lvbl;
    logic                   hs;
    logic                   vs;
    vid_ctrl_t              ctrl;
    vid_out_t               vid;
    logic                   vid_cen;

    stim_row_t rows [NUM_ROWS];
    vid_out_t  exp_q [$];
    logic [31:0] lcg_state;
    int check_count;
    int stream_errors;
    int run_errors;

    // Reference model state
    logic [`VID_COLORW-1:0] last_r;
    logic [`VID_COLORW-1:0] last_g;
    logic [`VID_COLORW-1:0] last_b;
    logic                   last_lhbl;
    logic                   odd_line;

    vid_board_top i_dut (
        .clk_sys ( clk_sys ),
        .rst_n   ( rst_n   ),
        .pxl_cen ( pxl_cen ),
        .game_r  ( game_r  ),
        .game_g  ( game_g  ),
        .game_b  ( game_b  ),
        .lhbl    ( lhbl    ),
        .lvbl    ( lvbl    ),
        .hs      ( hs      ),
        .vs      ( vs      ),
        .ctrl    ( ctrl    ),
        .vid     ( vid     ),
        .vid_cen ( vid_cen )
    );

    function automatic logic [31:0] next_lcg(input logic [31:0] s);
        next_lcg = s * 32'd1664525 + 32'd1013904223;
    endfunction

    // 0 random, 1 full scale, 2 alternating black and white
    function automatic logic [`VID_COLORW-1:0] pick_colour(
        input logic [1:0]             pattern,
        input logic [`VID_COLORW-1:0] rnd,
        input int                     x
    );
        case (pattern)
            2'd1:    pick_colour = '1;
            2'd2:    pick_colour = x[0] ? '1 : '0;
            default: pick_colour = rnd;
        endcase
    endfunction

    function automatic logic [`VID_FILTW-1:0] sum_or_double(
        input logic [`VID_COLORW-1:0] cur,
        input logic [`VID_COLORW-1:0] prev,
        input logic                   en
    );
        logic [`VID_FILTW-1:0] c;
        logic [`VID_FILTW-1:0] p;
        c = {1'b0, cur};
        p = {1'b0, prev};
        sum_or_double = en ? c + p : c + c;
    endfunction

    // Top bits repeat into the low end, so 5'h1f becomes 8'hff
    function automatic logic [`VID_OUTW-1:0] widen_to_8(input logic [`VID_FILTW-1:0] f);
        logic [`VID_OUTW-1:0] e;
        e = {{(`VID_OUTW - `VID_FILTW){1'b0}}, f};
        widen_to_8 = (e << (`VID_OUTW - `VID_FILTW)) | (e >> (2 * `VID_FILTW - `VID_OUTW));
    endfunction

    // Odd lines lose a quarter, keep a half or keep a quarter
    function automatic logic [`VID_OUTW-1:0] scanline_dim(
        input logic [`VID_OUTW-1:0] v,
        input logic                 odd,
        input sl_level_t            lvl
    );
        logic [`VID_OUTW-1:0] quarter;
        logic [`VID_OUTW-1:0] half;
        quarter = v / 8'd4;
        half    = v / 8'd2;
        scanline_dim = v;
        if (odd && lvl == 2'd1) begin
            scanline_dim = v - quarter;
        end else if (odd && lvl == 2'd2) begin
            scanline_dim = half;
        end else if (odd && lvl == 2'd3) begin
            scanline_dim = quarter;
        end
    endfunction

    // Queues what vid should show VID_LATENCY strobes after this pixel
    task automatic predict_pixel(input game_pixel_t px, input stim_row_t row);
        vid_out_t e;
        if (!px.lvbl) begin
            odd_line = 1'b0;
        end else if (last_lhbl && !px.lhbl) begin
            odd_line = !odd_line;
        end
        last_lhbl = px.lhbl;
        e = '0;
        e.hs = px.hs;
        e.vs = px.vs;
        e.de = px.lhbl && px.lvbl;
        if (e.de) begin
            e.r = scanline_dim(widen_to_8(sum_or_double(px.r, last_r, row.bw_en)), odd_line,
                               row.sl_mode);
            e.g = scanline_dim(widen_to_8(sum_or_double(px.g, last_g, row.bw_en)), odd_line,
                               row.sl_mode);
            e.b = scanline_dim(widen_to_8(sum_or_double(px.b, last_b, row.bw_en)), odd_line,
                               row.sl_mode);
        end
        last_r = px.r;
        last_g = px.g;
        last_b = px.b;
        exp_q.push_back(e);
    endtask

    // Returns on the edge where the DUT samples the pixel
    task automatic drive_pixel(input game_pixel_t px, input stim_row_t row);
        @(posedge clk_sys);
        pxl_cen <= 1'b1;
        game_r  <= px.r;
        game_g  <= px.g;
        game_b  <= px.b;
        lhbl    <= px.lhbl;
        lvbl    <= px.lvbl;
        hs      <= px.hs;
        vs      <= px.vs;
        ctrl    <= '{bw_en: row.bw_en, sl_mode: row.sl_mode};
        @(posedge clk_sys);
        pxl_cen <= 1'b0;
    endtask

    task automatic run_frame(input stim_row_t row);
        game_pixel_t px;
        for (int y = 0; y < FRAME_LINES; y++) begin
            for (int x = 0; x < LINE_PIX; x++) begin
                lcg_state = next_lcg(lcg_state);
                px = '0;
                px.r    = pick_colour(row.pattern, lcg_state[31:28], x);
                px.g    = pick_colour(row.pattern, lcg_state[27:24], x);
                px.b    = pick_colour(row.pattern, lcg_state[23:20], x);
                px.lhbl = (x < LINE_PIX - BLANK_PIX);
                px.lvbl = (y != 0);
                px.hs   = (x == LINE_PIX - 2);
                px.vs   = (y == 0) && (x < 4);
                drive_pixel(px, row);
                predict_pixel(px, row);
            end
        end
    endtask

    task automatic check_colour(input string name, input logic [`VID_OUTW-1:0] got,
                                input logic [`VID_OUTW-1:0] exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
            stream_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%h expected 0x%h at %0t", name, got, exp, $time);
            stream_errors++;
        end
    endtask

    task automatic check_output;
        vid_out_t e;
        if (exp_q.size() == 0) begin
            $display("vid_cen pulsed with no pixel expected at %0t", $time);
            stream_errors++;
        end else begin
            e = exp_q.pop_front();
            check_count++;
            check_colour("vid.r", vid.r, e.r);
            check_colour("vid.g", vid.g, e.g);
            check_colour("vid.b", vid.b, e.b);
            check_flag("vid.hs", vid.hs, e.hs);
            check_flag("vid.vs", vid.vs, e.vs);
            check_flag("vid.de", vid.de, e.de);
        end
    endtask

    initial begin
        clk_sys = 1'b0;
        forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
    end

    // Outputs are stable at the falling edge
    always @(negedge clk_sys) begin
        if (rst_n && vid_cen) begin
            check_output();
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: run still busy after %0d ns", WATCHDOG_NS);
        $display("checks %0d, stream errors %0d, run errors %0d",
                 check_count, stream_errors, run_errors);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        rst_n   = 1'b0;
        pxl_cen = 1'b0;
        game_r  = '0;
        game_g  = '0;
        game_b  = '0;
        lhbl    = 1'b0;
        lvbl    = 1'b0;
        hs      = 1'b0;
        vs      = 1'b0;
        ctrl    = '0;
        lcg_state     = 32'h042a_e599;
        check_count   = 0;
        stream_errors = 0;
        run_errors    = 0;
        last_r    = '0;
        last_g    = '0;
        last_b    = '0;
        last_lhbl = 1'b0;
        odd_line  = 1'b0;

        rows[0] = '{bw_en: 1'b0, sl_mode: SL_OFF,  pattern: 2'd0};
        rows[1] = '{bw_en: 1'b1, sl_mode: SL_OFF,  pattern: 2'd0};
        rows[2] = '{bw_en: 1'b1, sl_mode: SL_OFF,  pattern: 2'd2};
        rows[3] = '{bw_en: 1'b0, sl_mode: SL_3Q,   pattern: 2'd1};
        rows[4] = '{bw_en: 1'b0, sl_mode: SL_HALF, pattern: 2'd0};
        rows[5] = '{bw_en: 1'b0, sl_mode: SL_1Q,   pattern: 2'd1};
        rows[6] = '{bw_en: 1'b1, sl_mode: SL_3Q,   pattern: 2'd0};
        rows[7] = '{bw_en: 1'b1, sl_mode: SL_1Q,   pattern: 2'd2};

        repeat (10) @(posedge clk_sys);
        rst_n <= 1'b1;

        // No strobe yet, so the output still holds its reset value
        @(negedge clk_sys);
        if (vid !== '0) begin
            $display("ERR vid got 0x%h expected 0x%h after reset", vid, 27'h0);
            run_errors++;
        end
        if (vid_cen !== 1'b0) begin
            $display("ERR vid_cen got 0x%h expected 0x0 after reset", vid_cen);
            run_errors++;
        end

        // The first outputs come from the cleared stage registers
        repeat (`VID_LATENCY - 1) exp_q.push_back('0);

        for (int i = 0; i < NUM_ROWS; i++) begin
            run_frame(rows[i]);
        end

        // Blank pixels push the last real pixel out
        repeat (`VID_LATENCY - 1) begin
            drive_pixel('0, rows[NUM_ROWS-1]);
            predict_pixel('0, rows[NUM_ROWS-1]);
        end
        @(negedge clk_sys);
        @(posedge clk_sys);

        if (check_count != TOTAL_STROBES) begin
            $display("Only %0d of %0d output pixels were seen", check_count, TOTAL_STROBES);
            run_errors++;
        end
        if (exp_q.size() != `VID_LATENCY - 1) begin
            $display("Pipeline holds %0d pixels at the end instead of %0d",
                     exp_q.size(), `VID_LATENCY - 1);
            run_errors++;
        end

        $display("checks %0d, stream errors %0d, run errors %0d",
                 check_count, stream_errors, run_errors);
        if (stream_errors == 0 && run_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
